// ==== hw/mem_pkg.sv ====
// memory side definitions
// widths, icache geometry, bus commands and the FSM states of both clients

`default_nettype none

package mem_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// address width
	localparam int xlen = 32;
	// one memory block, also the data bus width
	localparam int block_bits = 64;
	// response and reply tag width, tag 0 means no response
	localparam int tag_bits = 4;

	////////////////////////////////////////
	// icache geometry
	////////////////////////////////////////

	localparam int icache_lines = 32;
	// index is address bits 7..3
	localparam int index_bits = 5;
	// byte offset inside a block, not used for access
	localparam int offset_bits = 3;
	// upper address bits kept per line
	localparam int line_tag_bits = xlen - index_bits - offset_bits;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// memory bus command
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_command_t;

	// uncached data access sequencer
	typedef enum logic [1:0] {
		data_idle,
		data_request,
		data_wait
	} data_state_t;

	// icache miss handling
	typedef enum logic [1:0] {
		fill_idle,
		fill_request,
		fill_wait
	} fill_state_t;

endpackage

`default_nettype wire

// ==== hw/icache.sv ====
// direct-mapped instruction cache
// hits are reported combinationally, a miss fetches the whole block
// over the shared memory bus and writes the line when its tag returns

`timescale 1ns/1ps
`default_nettype none

module icache import mem_pkg::*; (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic [xlen-1:0]       fetch_addr,
	output logic      [block_bits-1:0] fetch_data,
	output logic                       fetch_valid,
	output bus_command_t               cache_command,
	output logic      [xlen-1:0]       cache_addr,
	input  wire logic [tag_bits-1:0]   cache_response,
	input  wire logic [block_bits-1:0] mem_data,
	input  wire logic [tag_bits-1:0]   mem_tag
);

	////////////////////////////////////////
	// line storage
	////////////////////////////////////////

	logic [block_bits-1:0]    line_data [icache_lines];
	logic [line_tag_bits-1:0] line_tag  [icache_lines];
	logic [icache_lines-1:0]  line_valid;

	// fill bookkeeping
	fill_state_t         state;
	fill_state_t         next_state;
	logic [xlen-1:0]     fill_addr;
	logic [tag_bits-1:0] fill_tag;

	// lookup fields of the current fetch
	logic [index_bits-1:0]    fetch_index;
	logic [line_tag_bits-1:0] fetch_line_tag;
	logic                     hit;

	// fields of the block being filled
	logic [index_bits-1:0]    fill_index;
	logic [line_tag_bits-1:0] fill_line_tag;
	logic                     fill_accepted;
	logic                     fill_done;

	assign fetch_index    = fetch_addr[offset_bits +: index_bits];
	assign fetch_line_tag = fetch_addr[xlen-1 -: line_tag_bits];
	assign fill_index     = fill_addr[offset_bits +: index_bits];
	assign fill_line_tag  = fill_addr[xlen-1 -: line_tag_bits];

	////////////////////////////////////////
	// hit path
	////////////////////////////////////////

	assign hit = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_line_tag);

	assign fetch_valid = hit;
	assign fetch_data  = line_data[fetch_index];

	////////////////////////////////////////
	// miss fill FSM
	////////////////////////////////////////

	// request follows the state only, so the bus is quiet right after reset
	assign cache_command = (state == fill_request) ? bus_load : bus_none;
	assign cache_addr    = fill_addr;

	assign fill_accepted = (state == fill_request) && (cache_response != '0);
	// tag 0 is never handed out, so a recorded tag can't match an idle bus
	assign fill_done     = (state == fill_wait) && (mem_tag == fill_tag);

	always_comb begin
		next_state = state;
		case (state)
			fill_idle: begin
				if (!hit) begin
					next_state = fill_request;
				end
			end
			fill_request: begin
				// hold the load until memory takes it
				if (fill_accepted) begin
					next_state = fill_wait;
				end
			end
			fill_wait: begin
				if (fill_done) begin
					next_state = fill_idle;
				end
			end
			default: next_state = fill_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fill_idle;
		end else begin
			state <= next_state;
		end
	end

	// block aligned miss address, kept for the whole fill
	always_ff @(posedge clock) begin
		if ((state == fill_idle) && !hit) begin
			fill_addr <= {fetch_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
		end
		if (fill_accepted) begin
			fill_tag <= cache_response;
		end
	end

	////////////////////////////////////////
	// line update
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (fill_done) begin
			line_data[fill_index] <= mem_data;
			line_tag[fill_index]  <= fill_line_tag;
		end
	end

	// all lines invalid out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_done) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/data_access_unit.sv ====
// uncached data access unit
// puts one load or store of a 64-bit block on the memory bus,
// retries while refused and waits for the tag of a load

`timescale 1ns/1ps
`default_nettype none

module data_access_unit import mem_pkg::*; (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire bus_command_t          data_command,
	input  wire logic [xlen-1:0]       data_addr,
	input  wire logic [block_bits-1:0] data_wdata,
	output logic      [block_bits-1:0] data_rdata,
	output logic                       data_done,
	output bus_command_t               unit_command,
	output logic      [xlen-1:0]       unit_addr,
	output logic      [block_bits-1:0] unit_wdata,
	input  wire logic [tag_bits-1:0]   unit_response,
	input  wire logic [block_bits-1:0] mem_data,
	input  wire logic [tag_bits-1:0]   mem_tag
);

	data_state_t           state;
	data_state_t           next_state;
	logic [tag_bits-1:0]   load_tag;
	logic [block_bits-1:0] rdata_hold;

	logic issuing;
	logic accepted;
	logic tag_match;

	////////////////////////////////////////
	// bus request
	////////////////////////////////////////

	// client holds its request stable, so it goes straight to the bus
	// in idle and again on every retry
	assign issuing  = (state != data_wait) && (data_command != bus_none);
	assign accepted = issuing && (unit_response != '0);

	assign unit_command = (state == data_wait) ? bus_none : data_command;
	assign unit_addr    = data_addr;
	assign unit_wdata   = data_wdata;

	// reply for our load, tag 0 never recorded
	assign tag_match = (state == data_wait) && (mem_tag == load_tag);

	////////////////////////////////////////
	// completion
	////////////////////////////////////////

	// store is done when taken, load when its tag shows up
	assign data_done  = (accepted && (data_command == bus_store)) || tag_match;
	assign data_rdata = tag_match ? mem_data : rdata_hold;

	always_comb begin
		next_state = state;
		case (state)
			data_idle, data_request: begin
				if (!issuing) begin
					next_state = data_idle;
				end else if (!accepted) begin
					// refused, keep asking
					next_state = data_request;
				end else if (data_command == bus_load) begin
					next_state = data_wait;
				end else begin
					next_state = data_idle;
				end
			end
			data_wait: begin
				if (tag_match) begin
					next_state = data_idle;
				end
			end
			default: next_state = data_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= data_idle;
		end else begin
			state <= next_state;
		end
	end

	// tag of the accepted load and the last returned block
	always_ff @(posedge clock) begin
		if (accepted && (data_command == bus_load)) begin
			load_tag <= unit_response;
		end
		if (tag_match) begin
			rdata_hold <= mem_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
// single port memory controller
// data requests win over icache fills, the response goes back to the
// granted client only, reply data and tag are shared by both

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
	input  wire bus_command_t          unit_command,
	input  wire logic [xlen-1:0]       unit_addr,
	input  wire logic [block_bits-1:0] unit_wdata,
	input  wire bus_command_t          cache_command,
	input  wire logic [xlen-1:0]       cache_addr,
	output logic      [tag_bits-1:0]   unit_response,
	output logic      [tag_bits-1:0]   cache_response,
	output bus_command_t               mem_command,
	output logic      [xlen-1:0]       mem_addr,
	output logic      [block_bits-1:0] mem_wdata,
	input  wire logic [tag_bits-1:0]   mem_response
);

	// data unit owns the bus whenever it asks
	logic unit_grant;

	assign unit_grant = (unit_command != bus_none);

	////////////////////////////////////////
	// request mux
	////////////////////////////////////////

	always_comb begin
		if (unit_grant) begin
			mem_command = unit_command;
			mem_addr    = unit_addr;
			mem_wdata   = unit_wdata;
		end else begin
			mem_command = cache_command;
			mem_addr    = cache_addr;
			// icache only loads
			mem_wdata   = '0;
		end
	end

	////////////////////////////////////////
	// response steering
	////////////////////////////////////////

	// the loser sees 0 and retries next cycle
	always_comb begin
		if (unit_grant) begin
			unit_response  = mem_response;
			cache_response = '0;
		end else begin
			unit_response  = '0;
			cache_response = mem_response;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_system.sv ====
// memory side top level
// icache and uncached data unit sharing one tagged memory port

`timescale 1ns/1ps
`default_nettype none

module mem_system import mem_pkg::*; (
	input  wire logic                  clock,
	input  wire logic                  reset,

	// fetch side
	input  wire logic [xlen-1:0]       fetch_addr,
	output logic      [block_bits-1:0] fetch_data,
	output logic                       fetch_valid,

	// data side
	input  wire bus_command_t          data_command,
	input  wire logic [xlen-1:0]       data_addr,
	input  wire logic [block_bits-1:0] data_wdata,
	output logic      [block_bits-1:0] data_rdata,
	output logic                       data_done,

	// memory side
	output bus_command_t               mem_command,
	output logic      [xlen-1:0]       mem_addr,
	output logic      [block_bits-1:0] mem_wdata,
	input  wire logic [tag_bits-1:0]   mem_response,
	input  wire logic [block_bits-1:0] mem_data,
	input  wire logic [tag_bits-1:0]   mem_tag
);

	// icache to controller
	bus_command_t        cache_command;
	logic [xlen-1:0]     cache_addr;
	logic [tag_bits-1:0] cache_response;

	// data unit to controller
	bus_command_t          unit_command;
	logic [xlen-1:0]       unit_addr;
	logic [block_bits-1:0] unit_wdata;
	logic [tag_bits-1:0]   unit_response;

	////////////////////////////////////////
	// clients
	////////////////////////////////////////

	icache icache_0 (
		.clock          (clock),
		.reset          (reset),
		.fetch_addr     (fetch_addr),
		.fetch_data     (fetch_data),
		.fetch_valid    (fetch_valid),
		.cache_command  (cache_command),
		.cache_addr     (cache_addr),
		.cache_response (cache_response),
		// replies broadcast, tag picks the owner
		.mem_data       (mem_data),
		.mem_tag        (mem_tag)
	);

	data_access_unit data_access_unit_0 (
		.clock         (clock),
		.reset         (reset),
		.data_command  (data_command),
		.data_addr     (data_addr),
		.data_wdata    (data_wdata),
		.data_rdata    (data_rdata),
		.data_done     (data_done),
		.unit_command  (unit_command),
		.unit_addr     (unit_addr),
		.unit_wdata    (unit_wdata),
		.unit_response (unit_response),
		.mem_data      (mem_data),
		.mem_tag       (mem_tag)
	);

	////////////////////////////////////////
	// memory port
	////////////////////////////////////////

	mem_arbiter mem_arbiter_0 (
		.unit_command   (unit_command),
		.unit_addr      (unit_addr),
		.unit_wdata     (unit_wdata),
		.cache_command  (cache_command),
		.cache_addr     (cache_addr),
		.unit_response  (unit_response),
		.cache_response (cache_response),
		.mem_command    (mem_command),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_response   (mem_response)
	);

endmodule

`default_nettype wire

// ==== test/mem_system_props.sv ====
// protocol properties of the memory side top level
// quiet reset, fetch hits, data request issue, bus hold on refusal

`timescale 1ns/1ps
`default_nettype none

module mem_system_props import mem_pkg::*; (
	input wire logic                  clock,
	input wire logic                  reset,
	input wire logic [xlen-1:0]       fetch_addr,
	input wire logic                  fetch_valid,
	input wire bus_command_t          data_command,
	input wire logic [xlen-1:0]       data_addr,
	input wire logic                  data_done,
	input wire bus_command_t          mem_command,
	input wire logic [xlen-1:0]       mem_addr,
	input wire logic [block_bits-1:0] mem_wdata,
	input wire logic [tag_bits-1:0]   mem_response
);

	int fail_count = 0;

	// last block seen per index, and whether it was seen valid
	logic [xlen-offset_bits-1:0] known_block [icache_lines];
	logic [icache_lines-1:0]     known_valid;
	logic [index_bits-1:0]       fetch_index;
	logic                        expect_hit;

	assign fetch_index = fetch_addr[offset_bits +: index_bits];
	assign expect_hit  = known_valid[fetch_index] &&
		(known_block[fetch_index] == fetch_addr[xlen-1:offset_bits]);

	always_ff @(posedge clock) begin
		if (reset) begin
			known_valid <= '0;
			for (int i = 0; i < icache_lines; i++) begin
				known_block[i] <= '0;
			end
		end else if (known_block[fetch_index] != fetch_addr[xlen-1:offset_bits]) begin
			// another block at this index, line may be replaced
			known_block[fetch_index] <= fetch_addr[xlen-1:offset_bits];
			known_valid[fetch_index] <= fetch_valid;
		end else if (fetch_valid) begin
			known_valid[fetch_index] <= 1'b1;
		end
	end

	////////////////////////////////////////
	// properties
	////////////////////////////////////////

	reset_quiet: assert property (@(posedge clock)
		$fell(reset) |-> (mem_command == bus_none) && !fetch_valid && !data_done)
	else begin
		$error("bus or outputs active in the first cycle after reset");
		fail_count++;
	end

	// filled line hits at once, no new load of it
	hit_no_refill: assert property (@(posedge clock) disable iff (reset)
		expect_hit |-> fetch_valid && !((mem_command == bus_load) &&
			(mem_addr[xlen-1:offset_bits] == fetch_addr[xlen-1:offset_bits])))
	else begin
		$error("fetch of a filled block missed or was loaded again");
		fail_count++;
	end

	data_issue: assert property (@(posedge clock) disable iff (reset)
		(data_command != bus_none) && (($past(data_command) == bus_none) || $past(data_done))
		|-> (mem_command == data_command) && (mem_addr == data_addr))
	else begin
		$error("data request not on the bus in its first cycle");
		fail_count++;
	end

	// refused command repeats unchanged
	retry_hold: assert property (@(posedge clock) disable iff (reset)
		(mem_command != bus_none) && (mem_response == '0) |=>
		(mem_command == $past(mem_command)) && (mem_addr == $past(mem_addr)) &&
		(mem_wdata == $past(mem_wdata)))
	else begin
		$error("refused bus command changed before acceptance");
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== test/mem_system_tb.sv ====
// testbench for the memory side top level
// tagged memory model with random refusals and overlapping replies,
// a fetch thread and a data thread running side by side

`timescale 1ns/1ps
`default_nettype none

module mem_system_tb import mem_pkg::*; ();

	localparam int wait_limit = 200;

	logic                  clock;
	logic                  reset;
	logic [xlen-1:0]       fetch_addr;
	logic [block_bits-1:0] fetch_data;
	logic                  fetch_valid;
	bus_command_t          data_command;
	logic [xlen-1:0]       data_addr;
	logic [block_bits-1:0] data_wdata;
	logic [block_bits-1:0] data_rdata;
	logic                  data_done;
	bus_command_t          mem_command;
	logic [xlen-1:0]       mem_addr;
	logic [block_bits-1:0] mem_wdata;
	logic [tag_bits-1:0]   mem_response;
	logic [block_bits-1:0] mem_data;
	logic [tag_bits-1:0]   mem_tag;

	// memory model state
	logic [block_bits-1:0] mem_array [64];
	logic                  refuse;
	logic [tag_bits-1:0]   next_tag;
	int                    now;
	int                    pend_due [$];
	logic [tag_bits-1:0]   pend_tag [$];
	logic [5:0]            pend_block [$];

	// shadow of the stores, plus bookkeeping
	logic [block_bits-1:0] stored_data [64];
	logic [63:0]           stored_valid;
	logic                  done_prev;
	int                    errors;
	int                    timeouts;

	mem_system dut (.*);

	bind mem_system mem_system_props props_0 (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.fetch_valid  (fetch_valid),
		.data_command (data_command),
		.data_addr    (data_addr),
		.data_done    (data_done),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_response (mem_response)
	);

	// initial content of a block, both halves alike
	function automatic logic [block_bits-1:0] block_pattern(input int unsigned a);
		logic [31:0] p;
		p = a * 32'h9e3779b9;
		return {p, p};
	endfunction

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	////////////////////////////////////////
	// tagged memory model
	////////////////////////////////////////

	// accepts in the same cycle unless refusing
	assign mem_response = ((mem_command != bus_none) && !refuse) ? next_tag : '0;

	always @(posedge clock) begin
		int slot;
		now = now + 1;
		slot = -1;
		if (reset) begin
			refuse   <= 1'b0;
			next_tag <= 4'd1;
			mem_tag  <= '0;
			pend_due.delete();
			pend_tag.delete();
			pend_block.delete();
		end else begin
			// one reply per cycle, first one that is due
			for (int i = 0; i < pend_due.size(); i++) begin
				if ((slot < 0) && (pend_due[i] <= now)) begin
					slot = i;
				end
			end
			if (slot >= 0) begin
				mem_tag  <= pend_tag[slot];
				mem_data <= mem_array[pend_block[slot]];
				pend_due.delete(slot);
				pend_tag.delete(slot);
				pend_block.delete(slot);
			end else begin
				mem_tag <= '0;
			end
			if (mem_response != '0) begin
				if (mem_command == bus_store) begin
					mem_array[mem_addr[8:3]] = mem_wdata;
				end else begin
					// visible 2 to 6 cycles after acceptance
					pend_due.push_back(now - 1 + int'($urandom_range(2, 6)));
					pend_tag.push_back(mem_response);
					pend_block.push_back(mem_addr[8:3]);
				end
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// about one cycle in four refused
			refuse <= ($urandom_range(0, 3) == 0);
		end
	end

	////////////////////////////////////////
	// fetch data and load data checks
	////////////////////////////////////////

	always @(posedge clock) begin
		logic [5:0]            block;
		logic [block_bits-1:0] expected;
		if (!reset) begin
			if (fetch_valid) begin
				assert (fetch_data == block_pattern(fetch_addr >> offset_bits)) else begin
					errors++;
					$display("mismatch at %0t: fetch block %0d gave %h", $time,
						fetch_addr >> offset_bits, fetch_data);
				end
			end
			assert (!(done_prev && data_done)) else begin
				errors++;
				$display("data_done stayed high for two cycles at %0t", $time);
			end
			if (data_done) begin
				block = data_addr[8:3];
				if (data_command == bus_store) begin
					stored_data[block]  = data_wdata;
					stored_valid[block] = 1'b1;
				end else begin
					expected = stored_valid[block] ? stored_data[block] : block_pattern(32'(block));
					assert (data_rdata == expected) else begin
						errors++;
						$display("mismatch at %0t: load block %0d gave %h, expected %h", $time,
							block, data_rdata, expected);
					end
				end
			end
		end
		done_prev <= data_done && !reset;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic fetch_block(input int unsigned block);
		int waited;
		waited = 0;
		fetch_addr <= (block << offset_bits) | $urandom_range(0, 7);
		do begin
			@(posedge clock);
			waited++;
		end while (!fetch_valid && (waited < wait_limit));
		if (!fetch_valid) begin
			timeouts++;
			$display("timeout: fetch of block %0d never became valid", block);
		end
	endtask

	task automatic data_access(input bus_command_t cmd, input int unsigned block);
		int waited;
		waited = 0;
		// a refused request is repeated next cycle, so no new data request may cut in
		while ((mem_command != bus_none) && (mem_response == '0) && (waited < wait_limit)) begin
			@(posedge clock);
			waited++;
		end
		if ((mem_command != bus_none) && (mem_response == '0)) begin
			timeouts++;
			$display("timeout: memory kept refusing the bus before a %s of block %0d",
				cmd.name(), block);
		end
		data_command <= cmd;
		data_addr    <= (block << offset_bits) | $urandom_range(0, 7);
		data_wdata   <= {$urandom(), $urandom()};
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (!data_done && (waited < wait_limit));
		data_command <= bus_none;
		if (!data_done) begin
			timeouts++;
			$display("timeout: %s of block %0d never finished", cmd.name(), block);
		end
	endtask

	initial begin
		void'($urandom(32'h601dd317));
		errors       = 0;
		timeouts     = 0;
		now          = 0;
		stored_valid = '0;
		for (int a = 0; a < 64; a++) begin
			mem_array[a[5:0]] = block_pattern(a);
		end
		reset        <= 1'b1;
		fetch_addr   <= '0;
		data_command <= bus_none;
		data_addr    <= '0;
		data_wdata   <= '0;
		mem_data     <= '0;
		mem_tag      <= '0;
		refuse       <= 1'b0;
		next_tag     <= 4'd1;
		done_prev    <= 1'b0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		// first cycle out of reset stays quiet on the data side
		@(posedge clock);
		fork
			begin
				// cold misses first, then mostly hits
				for (int i = 0; i < 48 && timeouts == 0; i++) begin
					fetch_block((i < 16) ? i : $urandom_range(0, 31));
				end
			end
			begin
				for (int j = 0; j < 40 && timeouts == 0; j++) begin
					data_access(($urandom_range(0, 1) == 0) ? bus_load : bus_store,
						32 + $urandom_range(0, 15));
					repeat ($urandom_range(1, 3)) @(posedge clock);
				end
			end
		join
		repeat (4) @(posedge clock);
		$display("errors: %0d check, %0d assertion, %0d timeout", errors,
			dut.props_0.fail_count, timeouts);
		if ((errors == 0) && (dut.props_0.fail_count == 0) && (timeouts == 0)) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/mem_pkg.sv
hw/icache.sv
hw/data_access_unit.sv
hw/mem_arbiter.sv
hw/mem_system.sv
test/mem_system_props.sv
test/mem_system_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory side testbench

TOP = mem_system_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

obj_dir/V$(TOP): flist.f hw/*.sv test/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/1ps hw/mem_pkg.sv hw/icache.sv \
		hw/data_access_unit.sv hw/mem_arbiter.sv hw/mem_system.sv --top-module mem_system

clean:
	rm -rf obj_dir sim.log
